/* src/flow_defs.svh */
// Field widths and table sizes for the flow lookup pipeline
// Included by the package and by every RTL file that sizes logic from them

`ifndef FLOW_DEFS_SVH
`define FLOW_DEFS_SVH

// Header field widths
`define FLOW_MAC_W       48
`define FLOW_IP_W        32
`define FLOW_PORT_W      16

// Action entry width, one per table entry
`define FLOW_ACT_W       8

// Match table geometry
`define FLOW_TBL_DEPTH   16
`define FLOW_TBL_ADDR_W  4

// Statistics counters
`define FLOW_CNT_W       32

// Ingress physical port tag
`define FLOW_SRC_W       8

`endif

/* src/flow_pkg.sv */
// Types shared by the flow lookup stages and the top level
// Refer to them with flow_pkg:: scoped names

`default_nettype none

`include "flow_defs.svh"

package flow_pkg;

   // {mac_dst, ip_dst, port_no}, port number in the low bits
   typedef logic [`FLOW_MAC_W+`FLOW_IP_W+`FLOW_PORT_W-1:0] hdr_t;

   // Sized for the MAC stage, narrower stages use the low bits
   typedef logic [`FLOW_MAC_W-1:0] key_t;

   typedef logic [`FLOW_ACT_W-1:0] act_t;

   // {hit, action}
   typedef logic [`FLOW_ACT_W:0] stage_res_t;

   // {port result, mac result, ip result}
   typedef logic [3*(`FLOW_ACT_W+1)-1:0] action_vec_t;

   typedef logic [`FLOW_CNT_W-1:0] count_t;

   typedef logic [`FLOW_SRC_W-1:0] src_port_t;

   typedef logic [`FLOW_TBL_ADDR_W-1:0] tbl_addr_t;

   // Selects a stage for table writes and counter access
   typedef enum logic [1:0] {
      STAGE_IP   = 2'd0,
      STAGE_MAC  = 2'd1,
      STAGE_PORT = 2'd2
   } stage_sel_t;

endpackage

`default_nettype wire

/* src/hdr_stream_if.sv */
// One header beat plus its action word, passed between lookup stages
// Valid/ready handshake, the beat moves when both are high on a clock edge

`timescale 1ns/1ps
`default_nettype none

`include "flow_defs.svh"

interface hdr_stream_if;

   logic                    valid;
   logic                    ready;
   flow_pkg::hdr_t          hdr;
   flow_pkg::src_port_t     src_port;
   flow_pkg::action_vec_t   action;

   // Upstream side
   modport source (
      output valid,
      output hdr,
      output src_port,
      output action,
      input  ready
   );

   // Downstream side
   modport sink (
      input  valid,
      input  hdr,
      input  src_port,
      input  action,
      output ready
   );

endinterface

`default_nettype wire

/* src/ternary_match_table.sv */
// Ternary key/mask table with a valid bit per entry
// Combinational priority match, lowest matching index wins

`timescale 1ns/1ps
`default_nettype none

`include "flow_defs.svh"

module ternary_match_table #(
   parameter int KEY_W = 32
) (
   input  wire logic                axi_aclk,
   input  wire logic                arst_n,

   input  wire logic                wr_en,
   input  flow_pkg::tbl_addr_t      wr_addr,
   input  wire logic [KEY_W-1:0]    wr_key,
   input  wire logic [KEY_W-1:0]    wr_mask,

   input  wire logic [KEY_W-1:0]    lookup_key,
   output logic                     hit,
   output flow_pkg::tbl_addr_t      hit_addr
);

   localparam int DEPTH = `FLOW_TBL_DEPTH;

   logic [KEY_W-1:0]  key_mem  [DEPTH];
   logic [KEY_W-1:0]  mask_mem [DEPTH];
   logic [DEPTH-1:0]  valid_q;
   logic [DEPTH-1:0]  match;

   // Entry valid bits, cleared only by reset
   always_ff @(posedge axi_aclk or negedge arst_n) begin
      if (!arst_n) begin
         valid_q <= '0;
      end else if (wr_en) begin
         valid_q[wr_addr] <= 1'b1;
      end
   end

   // Key and mask storage
   always_ff @(posedge axi_aclk) begin
      if (wr_en) begin
         key_mem[wr_addr]  <= wr_key;
         mask_mem[wr_addr] <= wr_mask;
      end
   end

   // A mask bit of one means the key bit must agree
   always_comb begin
      for (int i = 0; i < DEPTH; i++) begin
         match[i] = valid_q[i] && (((lookup_key ^ key_mem[i]) & mask_mem[i]) == '0);
      end
   end

   // Scan downwards so the lowest index is the last to assign
   always_comb begin
      hit      = 1'b0;
      hit_addr = '0;
      for (int i = DEPTH - 1; i >= 0; i--) begin
         if (match[i]) begin
            hit      = 1'b1;
            hit_addr = flow_pkg::tbl_addr_t'(i);
         end
      end
   end

   // A reported hit always points at a populated entry
   a_hit_valid : assert property (
      @(posedge axi_aclk) disable iff (!arst_n)
      hit |-> valid_q[hit_addr]
   );

endmodule

`default_nettype wire

/* src/flow_lookup_stage.sv */
// One lookup stage: ternary match on a header field, action read and result insert
// Single output register, so one beat in flight and full throughput

`timescale 1ns/1ps
`default_nettype none

`include "flow_defs.svh"

module flow_lookup_stage #(
   parameter int KEY_W   = 32,
   parameter int KEY_LSB = 16,
   parameter int RES_LSB = 0
) (
   input  wire logic             axi_aclk,
   input  wire logic             arst_n,

   hdr_stream_if.sink            in,
   hdr_stream_if.source          out,

   // Table write port
   input  wire logic             key_wren,
   input  wire logic             act_wren,
   input  flow_pkg::tbl_addr_t   wr_addr,
   input  flow_pkg::key_t        wr_key,
   input  flow_pkg::key_t        wr_mask,
   input  flow_pkg::act_t        wr_act,

   // Statistics
   input  wire logic             cnt_clr,
   output flow_pkg::count_t      hit_cnt,
   output flow_pkg::count_t      miss_cnt,
   output flow_pkg::count_t      total_cnt
);

   localparam int DEPTH = `FLOW_TBL_DEPTH;
   localparam int RES_W = $bits(flow_pkg::stage_res_t);

   logic                     lookup_hit;
   flow_pkg::tbl_addr_t      lookup_addr;
   logic [KEY_W-1:0]         lookup_key;
   flow_pkg::act_t           act_mem [DEPTH];
   flow_pkg::stage_res_t     res;
   flow_pkg::action_vec_t    action_nxt;
   logic                     accept;

   logic                     valid_q;
   flow_pkg::hdr_t           hdr_q;
   flow_pkg::src_port_t      src_q;
   flow_pkg::action_vec_t    action_q;

   assign lookup_key = in.hdr[KEY_LSB +: KEY_W];

   ternary_match_table #(
      .KEY_W      (KEY_W)
   ) u_tcam (
      .axi_aclk   (axi_aclk),
      .arst_n     (arst_n),
      .wr_en      (key_wren),
      .wr_addr    (wr_addr),
      .wr_key     (wr_key[KEY_W-1:0]),
      .wr_mask    (wr_mask[KEY_W-1:0]),
      .lookup_key (lookup_key),
      .hit        (lookup_hit),
      .hit_addr   (lookup_addr)
   );

   // Action memory, same addressing as the match table
   always_ff @(posedge axi_aclk) begin
      if (act_wren) begin
         act_mem[wr_addr] <= wr_act;
      end
   end

   // Miss leaves the slot all zero
   assign res = lookup_hit ? {1'b1, act_mem[lookup_addr]} : '0;

   always_comb begin
      action_nxt = in.action;
      action_nxt[RES_LSB +: RES_W] = res;
   end

   // Take a new beat when the register is empty or draining this cycle
   assign in.ready = !valid_q || out.ready;
   assign accept   = in.valid && in.ready;

   always_ff @(posedge axi_aclk or negedge arst_n) begin
      if (!arst_n) begin
         valid_q <= 1'b0;
      end else if (accept) begin
         valid_q <= 1'b1;
      end else if (out.ready) begin
         valid_q <= 1'b0;
      end
   end

   // Payload, loaded only on accept
   always_ff @(posedge axi_aclk) begin
      if (accept) begin
         hdr_q    <= in.hdr;
         src_q    <= in.src_port;
         action_q <= action_nxt;
      end
   end

   assign out.valid    = valid_q;
   assign out.hdr      = hdr_q;
   assign out.src_port = src_q;
   assign out.action   = action_q;

   // Counters, clear has priority over a same-cycle count
   always_ff @(posedge axi_aclk or negedge arst_n) begin
      if (!arst_n) begin
         hit_cnt   <= '0;
         miss_cnt  <= '0;
         total_cnt <= '0;
      end else if (cnt_clr) begin
         hit_cnt   <= '0;
         miss_cnt  <= '0;
         total_cnt <= '0;
      end else if (accept) begin
         total_cnt <= total_cnt + 1'b1;
         if (lookup_hit) begin
            hit_cnt <= hit_cnt + 1'b1;
         end else begin
            miss_cnt <= miss_cnt + 1'b1;
         end
      end
   end

   // Downstream sees a stable beat while it stalls
   a_out_stable : assert property (
      @(posedge axi_aclk) disable iff (!arst_n)
      (out.valid && !out.ready) |=>
         ($stable(out.hdr) && $stable(out.src_port) && $stable(out.action))
   );

endmodule

`default_nettype wire

/* src/flow_table_processor.sv */
// Three-stage flow lookup: IP destination, then MAC destination, then port number
// Table writes and counter access are plain strobes steered by a stage select

`timescale 1ns/1ps
`default_nettype none

`include "flow_defs.svh"

module flow_table_processor (
   input  wire logic                axi_aclk,
   input  wire logic                arst_n,

   // Header input stream
   input  wire logic                s_hdr_valid,
   output logic                     s_hdr_ready,
   input  flow_pkg::hdr_t           s_hdr_data,
   input  flow_pkg::src_port_t      s_hdr_src_port,

   // Header output stream with the action word
   output logic                     m_hdr_valid,
   input  wire logic                m_hdr_ready,
   output flow_pkg::hdr_t           m_hdr_data,
   output flow_pkg::src_port_t      m_hdr_src_port,
   output flow_pkg::action_vec_t    m_action,

   // Table write port
   input  flow_pkg::stage_sel_t     tbl_sel,
   input  flow_pkg::tbl_addr_t      tbl_addr,
   input  flow_pkg::key_t           tbl_key,
   input  flow_pkg::key_t           tbl_mask,
   input  flow_pkg::act_t           tbl_act,
   input  wire logic                key_wren,
   input  wire logic                act_wren,

   // Counter access
   input  flow_pkg::stage_sel_t     cnt_sel,
   input  wire logic                cnt_clr,
   output flow_pkg::count_t         cnt_hit,
   output flow_pkg::count_t         cnt_miss,
   output flow_pkg::count_t         cnt_total
);

   localparam int RES_W = $bits(flow_pkg::stage_res_t);

   // Field positions in hdr_t
   localparam int PORT_LSB = 0;
   localparam int IP_LSB   = `FLOW_PORT_W;
   localparam int MAC_LSB  = `FLOW_PORT_W + `FLOW_IP_W;

   hdr_stream_if link_in ();
   hdr_stream_if link_a ();
   hdr_stream_if link_b ();
   hdr_stream_if link_out ();

   logic [2:0]          key_we;
   logic [2:0]          act_we;
   logic [2:0]          clr;
   flow_pkg::count_t    hit_cnt   [3];
   flow_pkg::count_t    miss_cnt  [3];
   flow_pkg::count_t    total_cnt [3];

   // Ingress, the action word starts empty
   assign link_in.valid    = s_hdr_valid;
   assign link_in.hdr      = s_hdr_data;
   assign link_in.src_port = s_hdr_src_port;
   assign link_in.action   = '0;
   assign s_hdr_ready      = link_in.ready;

   // Egress
   assign m_hdr_valid      = link_out.valid;
   assign m_hdr_data       = link_out.hdr;
   assign m_hdr_src_port   = link_out.src_port;
   assign m_action         = link_out.action;
   assign link_out.ready   = m_hdr_ready;

   // Steer the write and clear strobes to one stage
   always_comb begin
      key_we = '0;
      act_we = '0;
      clr    = '0;
      key_we[tbl_sel] = key_wren;
      act_we[tbl_sel] = act_wren;
      clr[cnt_sel]    = cnt_clr;
   end

   flow_lookup_stage #(
      .KEY_W     (`FLOW_IP_W),
      .KEY_LSB   (IP_LSB),
      .RES_LSB   (0)
   ) stage_ip (
      .axi_aclk  (axi_aclk),
      .arst_n    (arst_n),
      .in        (link_in),
      .out       (link_a),
      .key_wren  (key_we[flow_pkg::STAGE_IP]),
      .act_wren  (act_we[flow_pkg::STAGE_IP]),
      .wr_addr   (tbl_addr),
      .wr_key    (tbl_key),
      .wr_mask   (tbl_mask),
      .wr_act    (tbl_act),
      .cnt_clr   (clr[flow_pkg::STAGE_IP]),
      .hit_cnt   (hit_cnt[0]),
      .miss_cnt  (miss_cnt[0]),
      .total_cnt (total_cnt[0])
   );

   flow_lookup_stage #(
      .KEY_W     (`FLOW_MAC_W),
      .KEY_LSB   (MAC_LSB),
      .RES_LSB   (RES_W)
   ) stage_mac (
      .axi_aclk  (axi_aclk),
      .arst_n    (arst_n),
      .in        (link_a),
      .out       (link_b),
      .key_wren  (key_we[flow_pkg::STAGE_MAC]),
      .act_wren  (act_we[flow_pkg::STAGE_MAC]),
      .wr_addr   (tbl_addr),
      .wr_key    (tbl_key),
      .wr_mask   (tbl_mask),
      .wr_act    (tbl_act),
      .cnt_clr   (clr[flow_pkg::STAGE_MAC]),
      .hit_cnt   (hit_cnt[1]),
      .miss_cnt  (miss_cnt[1]),
      .total_cnt (total_cnt[1])
   );

   flow_lookup_stage #(
      .KEY_W     (`FLOW_PORT_W),
      .KEY_LSB   (PORT_LSB),
      .RES_LSB   (2 * RES_W)
   ) stage_port (
      .axi_aclk  (axi_aclk),
      .arst_n    (arst_n),
      .in        (link_b),
      .out       (link_out),
      .key_wren  (key_we[flow_pkg::STAGE_PORT]),
      .act_wren  (act_we[flow_pkg::STAGE_PORT]),
      .wr_addr   (tbl_addr),
      .wr_key    (tbl_key),
      .wr_mask   (tbl_mask),
      .wr_act    (tbl_act),
      .cnt_clr   (clr[flow_pkg::STAGE_PORT]),
      .hit_cnt   (hit_cnt[2]),
      .miss_cnt  (miss_cnt[2]),
      .total_cnt (total_cnt[2])
   );

   // Counter read mux, unused select code reads zero
   always_comb begin
      case (cnt_sel)
         flow_pkg::STAGE_IP: begin
            cnt_hit   = hit_cnt[0];
            cnt_miss  = miss_cnt[0];
            cnt_total = total_cnt[0];
         end
         flow_pkg::STAGE_MAC: begin
            cnt_hit   = hit_cnt[1];
            cnt_miss  = miss_cnt[1];
            cnt_total = total_cnt[1];
         end
         flow_pkg::STAGE_PORT: begin
            cnt_hit   = hit_cnt[2];
            cnt_miss  = miss_cnt[2];
            cnt_total = total_cnt[2];
         end
         default: begin
            cnt_hit   = '0;
            cnt_miss  = '0;
            cnt_total = '0;
         end
      endcase
   end

endmodule

`default_nettype wire

/* testbench/tb_flow_table_processor.sv */
// Self-checking testbench for the three-stage flow lookup pipeline
// Replays table writes, packets and counter checks from testbench/flow_golden.txt

`timescale 1ns/1ps
`default_nettype none

module tb_flow_table_processor;

   localparam int CLK_HALF    = 10;
   localparam int SEND_LIMIT  = 200;
   localparam int DRAIN_LIMIT = 500;

   logic                    axi_aclk;
   logic                    arst_n;
   logic                    s_hdr_valid;
   logic                    s_hdr_ready;
   flow_pkg::hdr_t          s_hdr_data;
   flow_pkg::src_port_t     s_hdr_src_port;
   logic                    m_hdr_valid;
   logic                    m_hdr_ready;
   flow_pkg::hdr_t          m_hdr_data;
   flow_pkg::src_port_t     m_hdr_src_port;
   flow_pkg::action_vec_t   m_action;
   flow_pkg::stage_sel_t    tbl_sel;
   flow_pkg::tbl_addr_t     tbl_addr;
   flow_pkg::key_t          tbl_key;
   flow_pkg::key_t          tbl_mask;
   flow_pkg::act_t          tbl_act;
   logic                    key_wren;
   logic                    act_wren;
   flow_pkg::stage_sel_t    cnt_sel;
   logic                    cnt_clr;
   flow_pkg::count_t        cnt_hit;
   flow_pkg::count_t        cnt_miss;
   flow_pkg::count_t        cnt_total;

   // Expected output beats in send order
   string                   exp_name   [$];
   flow_pkg::hdr_t          exp_hdr    [$];
   flow_pkg::src_port_t     exp_src    [$];
   flow_pkg::action_vec_t   exp_action [$];

   int    value_errors;
   int    other_errors;
   int    beats_checked;
   bit    timed_out;
   bit    bp_enable;

   flow_table_processor uut (
      .axi_aclk       (axi_aclk),
      .arst_n         (arst_n),
      .s_hdr_valid    (s_hdr_valid),
      .s_hdr_ready    (s_hdr_ready),
      .s_hdr_data     (s_hdr_data),
      .s_hdr_src_port (s_hdr_src_port),
      .m_hdr_valid    (m_hdr_valid),
      .m_hdr_ready    (m_hdr_ready),
      .m_hdr_data     (m_hdr_data),
      .m_hdr_src_port (m_hdr_src_port),
      .m_action       (m_action),
      .tbl_sel        (tbl_sel),
      .tbl_addr       (tbl_addr),
      .tbl_key        (tbl_key),
      .tbl_mask       (tbl_mask),
      .tbl_act        (tbl_act),
      .key_wren       (key_wren),
      .act_wren       (act_wren),
      .cnt_sel        (cnt_sel),
      .cnt_clr        (cnt_clr),
      .cnt_hit        (cnt_hit),
      .cnt_miss       (cnt_miss),
      .cnt_total      (cnt_total)
   );

   always #CLK_HALF axi_aclk = ~axi_aclk;

   // Sink ready with random stalls under back-pressure
   initial begin
      void'($urandom(32'ha6eb));
      forever begin
         @(posedge axi_aclk);
         if (bp_enable) begin
            m_hdr_ready <= (($urandom % 4) != 0);
         end else begin
            m_hdr_ready <= 1'b1;
         end
      end
   end

   task automatic check_action(input string name, input flow_pkg::action_vec_t exp_v,
                               input flow_pkg::action_vec_t act_v);
      if (act_v !== exp_v) begin
         value_errors++;
         $display("[ERROR] %s action: expected %h, actual %h", name, exp_v, act_v);
      end
   endtask

   task automatic check_hdr(input string name, input flow_pkg::hdr_t exp_v,
                            input flow_pkg::hdr_t act_v);
      if (act_v !== exp_v) begin
         value_errors++;
         $display("[ERROR] %s header: expected %h, actual %h", name, exp_v, act_v);
      end
   endtask

   task automatic check_src(input string name, input flow_pkg::src_port_t exp_v,
                            input flow_pkg::src_port_t act_v);
      if (act_v !== exp_v) begin
         value_errors++;
         $display("[ERROR] %s source port: expected %h, actual %h", name, exp_v, act_v);
      end
   endtask

   task automatic check_count(input string name, input flow_pkg::count_t exp_v,
                              input flow_pkg::count_t act_v);
      if (act_v !== exp_v) begin
         value_errors++;
         $display("[ERROR] %s: expected %0d, actual %0d", name, exp_v, act_v);
      end
   endtask

   // Outputs settle by the falling edge and the beat moves on the next rising one
   always @(negedge axi_aclk) begin
      if (arst_n && m_hdr_valid && m_hdr_ready) begin
         if (exp_action.size() == 0) begin
            other_errors++;
            $display("Output beat arrived with no packet expected, header %h", m_hdr_data);
         end else begin
            check_action(exp_name[0], exp_action[0], m_action);
            check_hdr(exp_name[0], exp_hdr[0], m_hdr_data);
            check_src(exp_name[0], exp_src[0], m_hdr_src_port);
            void'(exp_name.pop_front());
            void'(exp_hdr.pop_front());
            void'(exp_src.pop_front());
            void'(exp_action.pop_front());
            beats_checked++;
         end
      end
   end

   task automatic release_input();
      @(posedge axi_aclk);
      s_hdr_valid <= 1'b0;
   endtask

   task automatic wait_drain();
      int cycles;
      cycles = 0;
      while (exp_action.size() != 0 && cycles < DRAIN_LIMIT) begin
         @(posedge axi_aclk);
         cycles++;
      end
      if (exp_action.size() != 0) begin
         other_errors++;
         timed_out = 1'b1;
         $display("Timeout waiting for the pipeline to drain, %0d packets missing",
                  exp_action.size());
      end
   endtask

   task automatic send_packet(input string name, input flow_pkg::hdr_t hdr,
                              input flow_pkg::src_port_t src,
                              input flow_pkg::action_vec_t action);
      int cycles;
      bit accepted;
      @(posedge axi_aclk);
      exp_name.push_back(name);
      exp_hdr.push_back(hdr);
      exp_src.push_back(src);
      exp_action.push_back(action);
      s_hdr_valid    <= 1'b1;
      s_hdr_data     <= hdr;
      s_hdr_src_port <= src;
      cycles   = 0;
      accepted = 1'b0;
      while (!accepted && cycles < SEND_LIMIT) begin
         @(negedge axi_aclk);
         cycles++;
         accepted = s_hdr_ready;
      end
      if (!accepted) begin
         other_errors++;
         timed_out = 1'b1;
         $display("Timeout waiting for the input to accept packet %s", name);
      end
   endtask

   task automatic write_entry(input flow_pkg::stage_sel_t sel, input flow_pkg::tbl_addr_t addr,
                              input flow_pkg::key_t key, input flow_pkg::key_t mask,
                              input flow_pkg::act_t act);
      release_input();
      wait_drain();
      if (!timed_out) begin
         @(posedge axi_aclk);
         tbl_sel  <= sel;
         tbl_addr <= addr;
         tbl_key  <= key;
         tbl_mask <= mask;
         tbl_act  <= act;
         key_wren <= 1'b1;
         act_wren <= 1'b1;
         @(posedge axi_aclk);
         key_wren <= 1'b0;
         act_wren <= 1'b0;
      end
   endtask

   task automatic check_counters(input string name, input flow_pkg::stage_sel_t sel,
                                 input flow_pkg::count_t hit, input flow_pkg::count_t miss,
                                 input flow_pkg::count_t total, input bit clear);
      release_input();
      wait_drain();
      if (!timed_out) begin
         @(posedge axi_aclk);
         cnt_sel <= sel;
         @(negedge axi_aclk);
         check_count({name, " hit"}, hit, cnt_hit);
         check_count({name, " miss"}, miss, cnt_miss);
         check_count({name, " total"}, total, cnt_total);
         if (clear) begin
            @(posedge axi_aclk);
            cnt_clr <= 1'b1;
            @(posedge axi_aclk);
            cnt_clr <= 1'b0;
         end
      end
   endtask

   initial begin
      int                      fd;
      int                      n;
      int                      line_no;
      string                   text;
      string                   name;
      int                      stage_i;
      int                      flag_i;
      flow_pkg::tbl_addr_t     addr;
      flow_pkg::key_t          key;
      flow_pkg::key_t          mask;
      flow_pkg::act_t          act;
      flow_pkg::hdr_t          hdr;
      flow_pkg::src_port_t     src;
      flow_pkg::action_vec_t   action;
      flow_pkg::count_t        c_hit;
      flow_pkg::count_t        c_miss;
      flow_pkg::count_t        c_total;

      axi_aclk       = 1'b0;
      arst_n         = 1'b0;
      s_hdr_valid    = 1'b0;
      s_hdr_data     = '0;
      s_hdr_src_port = '0;
      m_hdr_ready    = 1'b0;
      tbl_sel        = flow_pkg::STAGE_IP;
      tbl_addr       = '0;
      tbl_key        = '0;
      tbl_mask       = '0;
      tbl_act        = '0;
      key_wren       = 1'b0;
      act_wren       = 1'b0;
      cnt_sel        = flow_pkg::STAGE_IP;
      cnt_clr        = 1'b0;
      value_errors   = 0;
      other_errors   = 0;
      beats_checked  = 0;
      timed_out      = 1'b0;
      bp_enable      = 1'b0;
      line_no        = 0;

      repeat (2) @(posedge axi_aclk);
      arst_n <= 1'b1;
      @(negedge axi_aclk);
      if (m_hdr_valid !== 1'b0) begin
         other_errors++;
         $display("Output valid is not low after reset");
      end

      fd = $fopen("testbench/flow_golden.txt", "r");
      if (fd == 0) begin
         other_errors++;
         $display("Cannot open testbench/flow_golden.txt for reading");
      end else begin
         while (!timed_out && $fgets(text, fd) != 0) begin
            line_no++;
            if (text.len() == 0 || text[0] == "#" || text[0] == "\n") begin
               continue;
            end
            case (text[0])
               "W": begin
                  n = $sscanf(text, "W %d %h %h %h %h", stage_i, addr, key, mask, act);
                  if (n == 5) begin
                     write_entry(flow_pkg::stage_sel_t'(stage_i), addr, key, mask, act);
                  end else begin
                     other_errors++;
                     $display("Malformed table write on golden line %0d", line_no);
                  end
               end
               "P": begin
                  n = $sscanf(text, "P %s %h %h %h", name, hdr, src, action);
                  if (n == 4) begin
                     send_packet(name, hdr, src, action);
                  end else begin
                     other_errors++;
                     $display("Malformed packet on golden line %0d", line_no);
                  end
               end
               "C": begin
                  n = $sscanf(text, "C %s %d %d %d %d %d", name, stage_i, c_hit, c_miss,
                              c_total, flag_i);
                  if (n == 6) begin
                     check_counters(name, flow_pkg::stage_sel_t'(stage_i), c_hit, c_miss,
                                    c_total, flag_i != 0);
                  end else begin
                     other_errors++;
                     $display("Malformed counter check on golden line %0d", line_no);
                  end
               end
               "B": begin
                  n = $sscanf(text, "B %d", flag_i);
                  if (n == 1) begin
                     release_input();
                     bp_enable <= (flag_i != 0);
                  end else begin
                     other_errors++;
                     $display("Malformed back-pressure setting on golden line %0d", line_no);
                  end
               end
               default: begin
                  other_errors++;
                  $display("Unknown command on golden line %0d", line_no);
               end
            endcase
         end
         $fclose(fd);
      end

      if (!timed_out) begin
         release_input();
         wait_drain();
      end
      repeat (5) @(posedge axi_aclk);

      $display("Checked %0d beats: %0d value errors, %0d other errors",
               beats_checked, value_errors, other_errors);
      if (value_errors == 0 && other_errors == 0) begin
         $display("All tests passed!");
      end else begin
         $display("Test failures found");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* testbench/flow_golden.txt */
# W stage addr key mask action          (stage 0 ip, 1 mac, 2 port, all hex but stage)
# P name header src expected_action     |  C name stage hit miss total clear  |  B backpressure
C reset_ip 0 0 0 0 0
P empty_0 0011223344550a0000010050 01 0000000
P empty_1 66778899aabbc0a8010501bb 02 0000000
P empty_2 ffffffffffffffffffffffff 03 0000000
C empty_ip 0 0 3 3 1
C clr_ip 0 0 0 0 0
C keep_mac 1 0 3 3 1
C keep_port 2 0 3 3 1
W 0 0 0000c0a80105 0000ffffffff 11
W 1 0 66778899aabb ffffffffffff 22
W 2 0 000000000050 00000000ffff 33
P exact_ip 001122334455c0a801050051 04 0000111
P exact_mac 66778899aabb0a00000101bb 05 0024400
P exact_port 0011223344550a0000010050 06 4cc0000
P exact_all 66778899aabbc0a801050050 07 4ce4511
W 0 1 0000c0a80000 0000ffff0000 44
W 0 2 00000a000000 0000ff000000 55
W 0 3 000000000000 000000000000 66
W 1 1 001122000000 ffffff000000 77
W 2 1 000000000050 00000000fff0 88
P mask_0 001122334455c0a802070051 08 622ef44
P mask_1 66778899aabb0a0000010050 09 4ce4555
P mask_2 aabbccddeeff0808080801bb 0a 0000166
P mask_3 001122ffffffc0a80105005f 0b 622ef11
B 1
P bp_0 66778899aabbc0a801050050 10 4ce4511
P bp_1 001122000001c0a8ffff005a 11 622ef44
P bp_2 0000000000000b0000000000 12 0000166
P bp_3 66778899aabb0a0a0a0a0060 13 0024555
P bp_4 001122334455c0a801050050 14 4ceef11
P bp_5 fedcba9876547f0000011f90 15 0000166
B 0
C final_ip 0 12 2 14 0
C final_mac 1 9 5 14 0
C final_port 2 8 6 14 1
C clr_port 2 0 0 0 0
C after_clr_mac 1 9 5 14 0

/* filelist.f */
+incdir+src
src/flow_pkg.sv
src/hdr_stream_if.sv
src/ternary_match_table.sv
src/flow_lookup_stage.sv
src/flow_table_processor.sv
testbench/tb_flow_table_processor.sv

/* Bender.yml */
package:
  name: flow_table_processor

sources:
  - include_dirs:
      - src
    files:
      - src/flow_pkg.sv
      - src/hdr_stream_if.sv
      - src/ternary_match_table.sv
      - src/flow_lookup_stage.sv
      - src/flow_table_processor.sv
  - target: simulation
    include_dirs:
      - src
    files:
      - testbench/tb_flow_table_processor.sv
